// File: dv/link_testdata.txt
# L cycles words = loopback, H cycles words = loopback with rx_ready low
# I data_hex k_hex = one raw beat, E err_count overflow_count = check counters
L 150 30
E 0 0
# Mixed K beat, lane 0 data, lanes 1 to 3 comma
I 50BC50BC50BC1234 E
L 50 10
E 1 0
# Bad K code on lane 2, link drops until the lane relocks
I 50BC111150BC50BC F
L 60 12
L 20 0
E 2 0
# Six words into a four word FIFO with the reader stalled
H 20 6
L 30 0
E 2 2
L 200 40
E 2 2

// File: tb.f
+incdir+src
src/link_pkg.sv
src/link_tx_framer.sv
src/link_rx_lane_sync.sv
src/link_rx_deframer.sv
src/link_rx_fifo.sv
src/link_top.sv
dv/link_assertions.sv
dv/link_checker.sv
dv/link_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the link testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module link_tb -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vlink_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// File: dv/link_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_tb;

    localparam int LINK_UP_TIMEOUT = 50;     // Cycles allowed for the first lock
    localparam int DRAIN_TIMEOUT   = 200;    // Cycles allowed to empty the FIFO

    localparam link_pkg::phy_beat_t IDLE_BEAT = '{
        data:    {`LINK_LANES{`COMMA_WORD}},
        charisk: {`LINK_LANES{1'b1}}
    };

    logic                  clk125;
    logic                  reset;
    link_pkg::link_word_t  tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    link_pkg::phy_beat_t   tx_beat;
    link_pkg::phy_beat_t   rx_beat;          // Loopback mux output
    link_pkg::link_word_t  rx_data;
    logic                  rx_valid;
    logic                  rx_ready;
    logic                  link_up;
    link_pkg::count_t      err_count;
    link_pkg::count_t      ovf_count;

    int          checker_errors;
    int          pending;                    // Words the checker still expects
    int          model_err;
    int          model_ovf;
    int          tb_errors;
    bit          timed_out;
    bit          fire_last;                  // Word transfers at the coming edge
    logic [15:0] lfsr_q;

    initial clk125 = 1'b0;
    always #10 clk125 = ~clk125;             // 20 ns period

    link_top dut0 (
        .clk125_i (clk125), .reset_i (reset),
        .tx_data_i (tx_data), .tx_valid_i (tx_valid), .tx_ready_o (tx_ready),
        .tx_beat_o (tx_beat),
        .rx_beat_i (rx_beat), .rx_data_o (rx_data), .rx_valid_o (rx_valid),
        .rx_ready_i (rx_ready),
        .link_up_o (link_up), .err_count_o (err_count), .overflow_count_o (ovf_count)
    );

    link_checker checker0 (
        .clk125_i (clk125), .reset_i (reset),
        .tx_data_i (tx_data), .tx_valid_i (tx_valid), .tx_ready_i (tx_ready),
        .tx_beat_i (tx_beat), .rx_beat_i (rx_beat),
        .rx_data_i (rx_data), .rx_valid_i (rx_valid), .rx_ready_i (rx_ready),
        .link_up_i (link_up),
        .errors_o (checker_errors), .pending_o (pending),
        .model_err_o (model_err), .model_ovf_o (model_ovf)
    );

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        logic        fb;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            bits   = {bits[62:0], fb};
        end
        return bits;
    endfunction

    task automatic next_negedge;
        @(negedge clk125);
        rx_beat = tx_beat;                   // Default is loopback
    endtask

    // Loopback for a number of cycles, sending words with random gaps
    // Hold mode keeps rx_ready low and sends back to back
    task automatic run_loopback(input int cycles, input int words, input bit hold);
        int sent;
        int gap;
        int c;
        sent = 0;
        gap  = 0;
        for (c = 0; c <= cycles; c++) begin
            next_negedge();
            if (tx_valid && fire_last) begin
                sent++;                                  // Taken at the last edge
                tx_valid = 1'b0;
                gap      = hold ? 0 : 1 + int'(take_bits(2));
            end
            if (hold) rx_ready = 1'b0;
            else if (!rx_ready) rx_ready = 1'b1;         // Never two drops in a row
            else rx_ready = (take_bits(3) != 64'd7);
            if (c == cycles) begin
                tx_valid = 1'b0;                         // Closing cycle
            end else if (!tx_valid && sent < words) begin
                if (gap == 0) begin
                    tx_valid = 1'b1;
                    tx_data  = take_bits(64);
                end else begin
                    gap--;
                end
            end
            fire_last = tx_valid && tx_ready;            // Ready is stable here
        end
        if (sent != words) begin
            tb_errors++;
            $display("loopback step sent only %0d of %0d words", sent, words);
        end
    endtask

    task automatic inject_raw_beat(input link_pkg::link_word_t data, input link_pkg::lane_k_t k);
        next_negedge();
        rx_ready       = 1'b1;
        rx_beat.data    = data;                          // Replaces the looped idle
        rx_beat.charisk = k;
    endtask

    task automatic check_counters(input int exp_err, input int exp_ovf, input int line_no);
        if (err_count !== 16'(exp_err)) begin
            tb_errors++;
            $display("mismatch err_count_line%0d expected %0d actual %0d",
                     line_no, exp_err, err_count);
        end
        if (ovf_count !== 16'(exp_ovf)) begin
            tb_errors++;
            $display("mismatch overflow_count_line%0d expected %0d actual %0d",
                     line_no, exp_ovf, ovf_count);
        end
    endtask

    task automatic wait_link_up;
        int n;
        n = 0;
        while (!link_up && n < LINK_UP_TIMEOUT) begin
            next_negedge();
            n++;
        end
        if (!link_up) begin
            timed_out = 1'b1;
            $display("timeout waiting for link up after reset");
        end else if (n != `LOCK_RUN) begin
            tb_errors++;
            $display("mismatch link_up_latency expected %0d actual %0d", `LOCK_RUN, n);
        end
    endtask

    task automatic drain_output;
        int n;
        n = 0;
        while (n < 3 || ((pending != 0 || rx_valid) && n < DRAIN_TIMEOUT)) begin
            next_negedge();
            rx_ready = 1'b1;
            n++;
        end
        if (pending != 0 || rx_valid) begin
            timed_out = 1'b1;
            $display("timeout waiting for %0d words to leave the FIFO", pending);
        end
    endtask

    // One line of the data file
    task automatic run_step(input string line, input int line_no);
        byte         op;
        int          a;
        int          b;
        logic [63:0] d;
        logic [63:0] k;
        int          n;
        if (line.len() < 2 || line.getc(0) == "#") return;
        op = line.getc(0);
        if (op == "I") n = $sscanf(line, "%c %h %h", op, d, k);
        else n = $sscanf(line, "%c %d %d", op, a, b);
        if (n != 3) begin
            tb_errors++;
            $display("line %0d of the data file cannot be parsed", line_no);
            return;
        end
        case (op)
            "L": run_loopback(a, b, 1'b0);
            "H": run_loopback(a, b, 1'b1);
            "I": inject_raw_beat(d, k[`LINK_LANES-1:0]);
            "E": check_counters(a, b, line_no);
            default: begin
                tb_errors++;
                $display("line %0d of the data file has unknown step %c", line_no, op);
            end
        endcase
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int    fd;
        string line;
        int    line_no;
        lfsr_q    = 16'd33880;
        reset     = 1'b1;
        tx_valid  = 1'b0;
        tx_data   = '0;
        rx_ready  = 1'b1;
        rx_beat   = IDLE_BEAT;
        fire_last = 1'b0;
        tb_errors = 0;
        timed_out = 1'b0;
        repeat (5) next_negedge();            // Reset for 5 cycles
        reset = 1'b0;
        wait_link_up();
        if (!timed_out) begin
            fd = $fopen("dv/link_testdata.txt", "r");
            if (fd == 0) begin
                tb_errors++;
                $display("cannot open dv/link_testdata.txt");
            end else begin
                line_no = 0;
                while (!timed_out && $fgets(line, fd) != 0) begin
                    line_no++;
                    run_step(line, line_no);
                end
                $fclose(fd);
            end
        end
        if (!timed_out) drain_output();
        if (err_count !== 16'(model_err)) begin
            tb_errors++;
            $display("mismatch final_err_count expected %0d actual %0d", model_err, err_count);
        end
        if (ovf_count !== 16'(model_ovf)) begin
            tb_errors++;
            $display("mismatch final_overflow_count expected %0d actual %0d",
                     model_ovf, ovf_count);
        end
        $display("errors: checker %0d testbench %0d timeout %0d",
                 checker_errors, tb_errors, timed_out);
        if (timed_out || checker_errors != 0 || tb_errors != 0) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/link_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_checker (
    input  wire                   clk125_i,
    input  wire                   reset_i,
    input  link_pkg::link_word_t  tx_data_i,
    input  wire                   tx_valid_i,
    input  wire                   tx_ready_i,
    input  link_pkg::phy_beat_t   tx_beat_i,
    input  link_pkg::phy_beat_t   rx_beat_i,
    input  link_pkg::link_word_t  rx_data_i,
    input  wire                   rx_valid_i,
    input  wire                   rx_ready_i,
    input  wire                   link_up_i,
    output int                    errors_o,      // Checks failed so far
    output int                    pending_o,     // Words predicted but not yet out
    output int                    model_err_o,   // Predicted err_count_o
    output int                    model_ovf_o    // Predicted overflow_count_o
);

    localparam link_pkg::phy_beat_t IDLE_BEAT = '{
        data:    {`LINK_LANES{`COMMA_WORD}},
        charisk: {`LINK_LANES{1'b1}}
    };

    link_pkg::link_word_t  kept [$];              // Expected FIFO contents
    int                    lane_run [`LINK_LANES];
    bit                    lane_lock [`LINK_LANES];
    bit                    up_q;                  // Lock model after the last edge
    bit                    wr_pend;               // Kept beat reaches the FIFO next edge
    link_pkg::link_word_t  wr_word;
    bit                    tx_fire_q;
    link_pkg::link_word_t  tx_word_q;
    int                    slot;                  // Cycles since the last alignment slot
    int                    errors = 0;
    int                    model_err;
    int                    model_ovf;
    int                    pending;

    task automatic note_mismatch(input string name, input logic [67:0] exp,
                                 input logic [67:0] act);
        errors++;
        $display("mismatch %s expected %0h actual %0h", name, exp, act);
    endtask

    always @(posedge clk125_i) begin : watch
        link_pkg::phy_beat_t   exp_beat;
        link_pkg::lane_word_t  w;
        link_pkg::link_word_t  head;
        bit                    all_up;
        bit                    any_bad;
        int                    l;
        if (reset_i) begin
            kept.delete();
            for (l = 0; l < `LINK_LANES; l++) begin
                lane_run[l]  = 0;
                lane_lock[l] = 1'b0;
            end
            up_q      = 1'b0;
            wr_pend   = 1'b0;
            tx_fire_q = 1'b0;
            slot      = 0;
            model_err = 0;
            model_ovf = 0;
        end else begin
            // Framer slot at the first cycle and every ALIGN_PERIOD after
            if (tx_ready_i !== (slot != 0)) note_mismatch("align_slot", 68'(slot != 0),
                                                          68'(tx_ready_i));
            slot     = (slot == `ALIGN_PERIOD - 1) ? 0 : slot + 1;
            exp_beat = IDLE_BEAT;
            if (tx_fire_q) begin
                exp_beat.data    = tx_word_q;     // Word taken at the last edge
                exp_beat.charisk = '0;
            end
            if (tx_beat_i !== exp_beat) note_mismatch("tx_beat", exp_beat, tx_beat_i);
            tx_fire_q = tx_valid_i && tx_ready_i;
            tx_word_q = tx_data_i;

            if (link_up_i !== up_q) note_mismatch("link_up", 68'(up_q), 68'(link_up_i));

            // Output valid follows the expected occupancy
            if (rx_valid_i !== (kept.size() != 0)) begin
                note_mismatch("rx_valid", 68'(kept.size() != 0), 68'(rx_valid_i));
            end
            if (rx_valid_i && rx_ready_i) begin
                if (kept.size() == 0) begin
                    errors++;
                    $display("output word %0h left the FIFO with none expected", rx_data_i);
                end else begin
                    head = kept.pop_front();
                    if (rx_data_i !== head) note_mismatch("rx_data", 68'(head), 68'(rx_data_i));
                end
            end
            if (wr_pend) begin
                if (kept.size() < `FIFO_DEPTH) kept.push_back(wr_word);
                else model_ovf++;                 // Full and not drained
            end

            // Lane lock model on the beat sampled at this edge
            any_bad = 1'b0;
            all_up  = 1'b1;
            for (l = 0; l < `LINK_LANES; l++) begin
                w = rx_beat_i.data[l*`LANE_WIDTH +: `LANE_WIDTH];
                if (rx_beat_i.charisk[l] && w != `COMMA_WORD) begin
                    any_bad      = 1'b1;          // Bad K loses the lane
                    lane_lock[l] = 1'b0;
                    lane_run[l]  = 0;
                end else if (!lane_lock[l]) begin
                    if (rx_beat_i.charisk[l]) begin
                        lane_run[l]++;
                        if (lane_run[l] == `LOCK_RUN) lane_lock[l] = 1'b1;
                    end else begin
                        lane_run[l] = 0;          // Run broken
                    end
                end
                all_up = all_up && lane_lock[l];
            end
            if (any_bad || (all_up && rx_beat_i.charisk != '0 && rx_beat_i.charisk != '1)) begin
                model_err++;
            end
            up_q    = all_up;
            wr_pend = all_up && (rx_beat_i.charisk == '0);
            wr_word = rx_beat_i.data;
        end
        pending = kept.size() + (wr_pend ? 1 : 0);
    end

    assign errors_o    = errors;
    assign pending_o   = pending;
    assign model_err_o = model_err;
    assign model_ovf_o = model_ovf;

endmodule

`default_nettype wire

// File: dv/link_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_assertions (
    input  wire                   clk125_i,
    input  wire                   reset_i,
    input  link_pkg::phy_beat_t   tx_beat_i,
    input  link_pkg::link_word_t  rx_data_i,
    input  wire                   rx_valid_i,
    input  wire                   rx_ready_i,
    input  wire                   link_up_i
);

    localparam link_pkg::link_word_t IDLE_DATA = {`LINK_LANES{`COMMA_WORD}};

    // Output word held until it transfers
    hold_rx_word: assert property (@(posedge clk125_i) disable iff (reset_i)
        (rx_valid_i && !rx_ready_i) |=> (rx_valid_i && $stable(rx_data_i)))
        else $error("rx word dropped or changed before its transfer");

    // Only clean data beats or full comma idles on the wire
    tx_beat_form: assert property (@(posedge clk125_i) disable iff (reset_i)
        (tx_beat_i.charisk == '0) || (tx_beat_i.charisk == '1 && tx_beat_i.data == IDLE_DATA))
        else $error("tx beat is neither idle nor data");

    link_down_in_reset: assert property (@(posedge clk125_i)
        reset_i |=> !link_up_i)
        else $error("link up while in reset");

endmodule

bind link_top link_assertions assert0 (
    .clk125_i   (clk125_i),
    .reset_i    (reset_i),
    .tx_beat_i  (tx_beat_o),
    .rx_data_i  (rx_data_o),
    .rx_valid_i (rx_valid_o),
    .rx_ready_i (rx_ready_i),
    .link_up_i  (link_up_o)
);

`default_nettype wire

// File: src/link_top.sv
`timescale 1ns/1ps
`default_nettype none

module link_top (
    input  wire                   clk125_i,         // 125 MHz user clock
    input  wire                   reset_i,          // Sync, active high
    // Transmit side
    input  link_pkg::link_word_t  tx_data_i,        // Payload in
    input  wire                   tx_valid_i,
    output logic                  tx_ready_o,
    output link_pkg::phy_beat_t   tx_beat_o,        // To the transceiver
    // Receive side
    input  link_pkg::phy_beat_t   rx_beat_i,        // From the transceiver, every cycle
    output link_pkg::link_word_t  rx_data_o,        // Payload out
    output logic                  rx_valid_o,
    input  wire                   rx_ready_i,
    // Status
    output logic                  link_up_o,        // All lanes locked
    output link_pkg::count_t      err_count_o,      // Malformed beats
    output link_pkg::count_t      overflow_count_o  // Words lost to a full FIFO
);

    wire                         rx_wr_en;      // Deframer to FIFO
    wire link_pkg::link_word_t   rx_wr_data;

    //////////////////////////////
    // Transmit path
    //////////////////////////////

    link_tx_framer framer_i (
        .clk125_i  (clk125_i),
        .reset_i   (reset_i),
        .data_i    (tx_data_i),
        .valid_i   (tx_valid_i),
        .ready_o   (tx_ready_o),
        .beat_o    (tx_beat_o)
    );

    //////////////////////////////
    // Receive path
    //////////////////////////////

    link_rx_deframer deframer_i (
        .clk125_i     (clk125_i),
        .reset_i      (reset_i),
        .beat_i       (rx_beat_i),
        .wr_en_o      (rx_wr_en),
        .wr_data_o    (rx_wr_data),
        .link_up_o    (link_up_o),
        .err_count_o  (err_count_o)
    );

    link_rx_fifo fifo_i (
        .clk125_i          (clk125_i),
        .reset_i           (reset_i),
        .wr_en_i           (rx_wr_en),
        .wr_data_i         (rx_wr_data),
        .rd_data_o         (rx_data_o),
        .rd_valid_o        (rx_valid_o),
        .rd_ready_i        (rx_ready_i),
        .overflow_count_o  (overflow_count_o)
    );

endmodule

`default_nettype wire

// File: src/link_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_rx_fifo #(
    parameter int DEPTH = `FIFO_DEPTH           // Words held
) (
    input  wire                   clk125_i,         // 125 MHz user clock
    input  wire                   reset_i,          // Sync, active high
    input  wire                   wr_en_i,          // Write strobe, no back-pressure
    input  link_pkg::link_word_t  wr_data_i,        // Word to store
    output link_pkg::link_word_t  rd_data_o,        // Head of queue
    output logic                  rd_valid_o,       // Head is valid
    input  wire                   rd_ready_i,       // Consumer takes the head
    output link_pkg::count_t      overflow_count_o  // Dropped writes, saturating
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    link_pkg::link_word_t  mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr, rd_ptr;
    logic [CNT_W-1:0]      occ;               // Occupancy
    link_pkg::count_t      ovf_q;
    logic                  full;
    logic                  rd_fire;
    logic                  wr_fire;

    assign full    = (occ == CNT_W'(DEPTH));
    assign rd_fire = rd_valid_o && rd_ready_i;
    assign wr_fire = wr_en_i && (!full || rd_fire);   // Full but draining is fine

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk125_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_fire && !rd_fire) begin
                occ <= occ + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                occ <= occ - 1'b1;
            end
        end
    end

    always_ff @(posedge clk125_i) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Writes that find the FIFO full are dropped and counted as the link cannot stall
    always_ff @(posedge clk125_i) begin
        if (reset_i) begin
            ovf_q <= '0;
        end else if (wr_en_i && !wr_fire && (ovf_q != '1)) begin
            ovf_q <= ovf_q + 1'b1;
        end
    end

    assign rd_valid_o       = (occ != '0);
    assign rd_data_o        = mem[rd_ptr];    // Held until the read fires
    assign overflow_count_o = ovf_q;

endmodule

`default_nettype wire

// File: src/link_rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_rx_deframer (
    input  wire                   clk125_i,     // 125 MHz user clock
    input  wire                   reset_i,      // Sync, active high
    input  link_pkg::phy_beat_t   beat_i,       // Raw beat from the transceiver
    output logic                  wr_en_o,      // Data beat kept this cycle
    output link_pkg::link_word_t  wr_data_o,    // Kept word to the FIFO
    output logic                  link_up_o,    // All lanes locked
    output link_pkg::count_t      err_count_o   // Malformed beats, saturating
);

    wire link_pkg::link_word_t   lane_data;     // Registered lane words
    wire link_pkg::lane_k_t      lane_k;        // Registered K flags
    wire [`LINK_LANES-1:0]       lane_locked;
    wire [`LINK_LANES-1:0]       lane_bad_k;

    link_pkg::count_t  err_q;
    logic              beat_data;       // No K on any lane
    logic              beat_idle;       // K on every lane
    logic              beat_mixed;      // Some lanes K, some not
    logic              err_inc;

    //////////////////////////////
    // Per lane synchronisers
    //////////////////////////////

    genvar g;
    generate
        for (g = 0; g < `LINK_LANES; g = g + 1) begin : g_lane
            link_rx_lane_sync lane_sync_i (
                .clk125_i  (clk125_i),
                .reset_i   (reset_i),
                .word_i    (beat_i.data[g*`LANE_WIDTH +: `LANE_WIDTH]),
                .k_i       (beat_i.charisk[g]),
                .locked_o  (lane_locked[g]),
                .word_o    (lane_data[g*`LANE_WIDTH +: `LANE_WIDTH]),
                .k_o       (lane_k[g]),
                .bad_k_o   (lane_bad_k[g])
            );
        end
    endgenerate

    assign link_up_o = &lane_locked;     // Any lane down takes the link down

    //////////////////////////////
    // Beat classification
    //////////////////////////////

    assign beat_data  = ~|lane_k;
    assign beat_idle  = &lane_k;
    assign beat_mixed = !beat_data && !beat_idle;

    // Idle beats fall through, only clean data beats reach the FIFO
    assign wr_en_o   = link_up_o && beat_data;
    assign wr_data_o = lane_data;

    // One error per beat, either from a bad K code on any lane
    // or a mixed K pattern while aligned
    assign err_inc = (|lane_bad_k) || (link_up_o && beat_mixed);

    //////////////////////////////
    // Error counter
    //////////////////////////////

    always_ff @(posedge clk125_i) begin
        if (reset_i) begin
            err_q <= '0;
        end else if (err_inc && (err_q != '1)) begin
            err_q <= err_q + 1'b1;       // Sticks at all ones
        end
    end

    assign err_count_o = err_q;

endmodule

`default_nettype wire

// File: src/link_rx_lane_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_rx_lane_sync (
    input  wire                   clk125_i,   // 125 MHz user clock
    input  wire                   reset_i,    // Sync, active high
    input  link_pkg::lane_word_t  word_i,     // Lane word from the transceiver
    input  wire                   k_i,        // Lane char is K
    output logic                  locked_o,   // Lane aligned
    output link_pkg::lane_word_t  word_o,     // Word, one register later
    output logic                  k_o,        // K flag, one register later
    output logic                  bad_k_o     // K flag on a non-comma word
);

    localparam int RUN_W = $clog2(`LOCK_RUN + 1);
    localparam logic [RUN_W-1:0] RUN_LAST = RUN_W'(`LOCK_RUN - 1);

    link_pkg::sync_state_e  state_q, state_d;
    logic [RUN_W-1:0]       run_q, run_d;      // Commas seen in the current run
    link_pkg::lane_word_t   word_q;
    logic                   k_q;
    logic                   bad_k_q;
    logic                   is_comma;
    logic                   is_bad_k;

    assign is_comma = k_i && (word_i == `COMMA_WORD);
    assign is_bad_k = k_i && (word_i != `COMMA_WORD);  // Illegal K code

    //////////////////////////////
    // Lock FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        run_d   = run_q;
        unique case (state_q)
            link_pkg::SYNC_HUNT: begin
                if (is_comma) begin
                    state_d = link_pkg::SYNC_COUNT;   // First comma of a run
                    run_d   = RUN_W'(1);
                end
            end
            link_pkg::SYNC_COUNT: begin
                if (!is_comma) begin
                    state_d = link_pkg::SYNC_HUNT;    // Run broken
                    run_d   = '0;
                end else if (run_q == RUN_LAST) begin
                    state_d = link_pkg::SYNC_LOCKED;  // Full run seen
                end else begin
                    run_d = run_q + 1'b1;
                end
            end
            link_pkg::SYNC_LOCKED: begin
                state_d = link_pkg::SYNC_LOCKED;      // Holds through data beats
            end
            default: state_d = link_pkg::SYNC_HUNT;
        endcase
        // A bad K code loses alignment from any state
        if (is_bad_k) begin
            state_d = link_pkg::SYNC_HUNT;
            run_d   = '0;
        end
    end

    always_ff @(posedge clk125_i) begin
        if (reset_i) begin
            state_q <= link_pkg::SYNC_HUNT;
            run_q   <= '0;
            k_q     <= 1'b0;
            bad_k_q <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= run_d;
            k_q     <= k_i;
            bad_k_q <= is_bad_k;      // One cycle pulse per bad beat
        end
    end

    always_ff @(posedge clk125_i) begin
        word_q <= word_i;             // Lane payload
    end

    assign locked_o = (state_q == link_pkg::SYNC_LOCKED);
    assign word_o   = word_q;
    assign k_o      = k_q;
    assign bad_k_o  = bad_k_q;

endmodule

`default_nettype wire

// File: src/link_tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_tx_framer (
    input  wire                   clk125_i,   // 125 MHz user clock
    input  wire                   reset_i,    // Sync, active high
    input  link_pkg::link_word_t  data_i,     // Payload word, lane 0 low
    input  wire                   valid_i,    // Payload present
    output logic                  ready_o,    // Framer takes a word this cycle
    output link_pkg::phy_beat_t   beat_o      // Registered beat to the transceiver
);

    localparam int ALIGN_W = $clog2(`ALIGN_PERIOD);
    localparam logic [ALIGN_W-1:0] ALIGN_LAST = ALIGN_W'(`ALIGN_PERIOD - 1);

    // Comma on every lane with every K flag set
    localparam link_pkg::phy_beat_t IDLE_BEAT = '{
        data:    {`LINK_LANES{`COMMA_WORD}},
        charisk: {`LINK_LANES{1'b1}}
    };

    logic [ALIGN_W-1:0]   align_cnt;   // Free running slot counter
    link_pkg::phy_beat_t  beat_q;      // Beat on the wire
    logic                 accept;      // Word transfer this cycle

    //////////////////////////////
    // Alignment slot
    //////////////////////////////

    // Reset value is the last count, so the first cycle out of reset
    // is itself an alignment slot and the counter wraps at the first edge
    always_ff @(posedge clk125_i) begin
        if (reset_i) begin
            align_cnt <= ALIGN_LAST;
        end else if (align_cnt == ALIGN_LAST) begin
            align_cnt <= '0;                  // Wrap at the end of the slot
        end else begin
            align_cnt <= align_cnt + 1'b1;
        end
    end

    // Not ready in the slot cycle, next beat is then a forced comma
    assign ready_o = (align_cnt != ALIGN_LAST);
    assign accept  = valid_i && ready_o;

    //////////////////////////////
    // Beat register
    //////////////////////////////

    always_ff @(posedge clk125_i) begin
        if (reset_i) begin
            beat_q <= IDLE_BEAT;              // Idles straight out of reset
        end else if (accept) begin
            beat_q.data    <= data_i;         // Data beat, no K anywhere
            beat_q.charisk <= '0;
        end else begin
            beat_q <= IDLE_BEAT;              // Nothing to send or forced slot
        end
    end

    assign beat_o = beat_q;

endmodule

`default_nettype wire

// File: src/link_pkg.sv
`default_nettype none

`include "link_config.svh"

package link_pkg;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [`LANE_WIDTH-1:0]              lane_word_t;  // One lane, one beat
    typedef logic [`LINK_LANES-1:0]              lane_k_t;     // Char is K, one bit per lane
    typedef logic [`LINK_LANES*`LANE_WIDTH-1:0]  link_word_t;  // Lane 0 in the low bits
    typedef logic [15:0]                         count_t;      // Saturating status counter

    //////////////////////////////
    // Transceiver boundary
    //////////////////////////////

    // One parallel beat as the transceiver wrapper sees it
    typedef struct packed {
        link_word_t data;       // 4x16 bit lane data
        lane_k_t    charisk;    // K flag per lane
    } phy_beat_t;

    //////////////////////////////
    // Lane synchroniser FSM
    //////////////////////////////

    typedef enum logic [1:0] {
        SYNC_HUNT   = 2'd0,     // Waiting for a first comma
        SYNC_COUNT  = 2'd1,     // Counting a comma run
        SYNC_LOCKED = 2'd2      // Lane aligned, data trusted
    } sync_state_e;

endpackage

`default_nettype wire

// File: src/link_config.svh
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

//////////////////////////////
// Link geometry
//////////////////////////////

`define LINK_LANES    4        // Lanes per link, one transceiver channel each
`define LANE_WIDTH    16       // Parallel word per lane per beat

//////////////////////////////
// Idle and alignment
//////////////////////////////

// Idle lane word. K28.5 in the low byte, D16.2 in the high byte
// Only a comma when sent together with the lane K flag
`define COMMA_WORD    16'h50BC

`define LOCK_RUN      4        // Consecutive commas before a lane locks
`define ALIGN_PERIOD  16       // One forced comma beat per this many cycles

//////////////////////////////
// Receive buffering
//////////////////////////////

`define FIFO_DEPTH    4        // Default receive FIFO depth in words

`endif
